/* mmu.f */
source/mmu_pkg.sv
source/mem_map.sv
source/tlb.sv
source/tlb_random.sv
source/tlb_maint_fsm.sv
source/mmu_top.sv
test/mmu_props.sv
test/mmu_tb.sv

/* test/mmu_tb.sv */
`timescale 1ns/1ps

module mmu_tb;

  typedef enum logic [2:0] {
    APB_WR,
    APB_RD,
    RD_RANGE,
    XLATE,
    XLATE_OFF
  } row_kind_t;

  // flags on XLATE rows are {uncached, miss, illegal, dirty}.
  // bit 0 is pslverr on APB rows.
  typedef struct {
    string       name;
    row_kind_t   kind;
    logic [31:0] addr;
    logic [31:0] data;
    logic        user;
    logic [31:0] exp;
    logic [3:0]  flags;
  } row_t;

  logic               clk;
  logic               rst_n;
  logic               psel, penable, pwrite;
  mmu_pkg::apb_addr_t paddr;
  mmu_pkg::apb_data_t pwdata, prdata;
  logic               pready, pslverr;
  mmu_pkg::vaddr_t    inst_addr, data_addr;
  logic               inst_en, data_en, user_mode;
  mmu_pkg::paddr_t    inst_pa, data_pa;
  logic               inst_unc, data_unc, inst_miss, data_miss;
  logic               inst_ill, data_ill, data_dirty;

  row_t   rows[$];
  int     value_errs;
  int     timeouts;
  integer seed;

  mmu_top i_dut (
    .clk(clk), .rst_n_i(rst_n), .inst_addr_i(inst_addr), .data_addr_i(data_addr),
    .inst_en_i(inst_en), .data_en_i(data_en), .user_mode_i(user_mode),
    .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite), .paddr_i(paddr),
    .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr),
    .inst_addr_o(inst_pa), .data_addr_o(data_pa), .inst_uncached_o(inst_unc),
    .data_uncached_o(data_unc), .inst_exp_miss_o(inst_miss), .data_exp_miss_o(data_miss),
    .inst_exp_illegal_o(inst_ill), .data_exp_illegal_o(data_ill),
    .data_exp_dirty_o(data_dirty)
  );

  bind mmu_top mmu_props i_props (
    .clk(clk), .rst_n_i(rst_n_i), .psel_i(psel_i), .penable_i(penable_i),
    .pready_i(pready_o), .user_mode_i(user_mode_i), .inst_addr_i(inst_addr_i),
    .data_addr_i(data_addr_i), .inst_mapped_i(inst_mapped), .data_mapped_i(data_mapped),
    .inst_illegal_i(inst_exp_illegal_o), .data_illegal_i(data_exp_illegal_o),
    .inst_miss_i(inst_exp_miss_o), .data_miss_i(data_exp_miss_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] hi_word(input mmu_pkg::vpn2_t vpn2,
                                          input mmu_pkg::asid_t asid);
    return {vpn2, 5'd0, asid};
  endfunction

  function automatic logic [31:0] lo_word(input mmu_pkg::pfn_t pfn, input logic d,
                                          input logic v, input logic g);
    return {6'd0, pfn, 3'd0, d, v, g};
  endfunction

  function automatic void add_row(input string name, input row_kind_t kind,
                                  input logic [31:0] addr, input logic [31:0] data,
                                  input logic user, input logic [31:0] exp,
                                  input logic [3:0] flags);
    row_t r;
    r.name  = name;
    r.kind  = kind;
    r.addr  = addr;
    r.data  = data;
    r.user  = user;
    r.exp   = exp;
    r.flags = flags;
    rows.push_back(r);
  endfunction

  task automatic check_value(input string name, input string field,
                             input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      value_errs++;
      $display("ERR %s %s: expected %h, actual %h", name, field, exp, act);
    end
  endtask

  // one APB transfer from setup to the last access cycle.
  task automatic apb_transfer(input logic wr, input mmu_pkg::apb_addr_t addr,
                              input mmu_pkg::apb_data_t wdata,
                              output mmu_pkg::apb_data_t rdata, output logic err);
    int waits;
    waits = 0;
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    #1;
    while (!pready && waits < 16) begin
      @(negedge clk);
      #1;
      waits++;
    end
    rdata = prdata;
    err   = pslverr;
    assert (pready) else begin
      timeouts++;
      $display("timeout: pready_o never came for APB offset %h", addr);
    end
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic run_row(input row_t r);
    mmu_pkg::apb_data_t rdata;
    logic               err;
    case (r.kind)
      APB_WR: begin
        apb_transfer(1'b1, r.addr[7:0], r.data, rdata, err);
        check_value(r.name, "pslverr", r.flags[0], err);
      end
      APB_RD: begin
        apb_transfer(1'b0, r.addr[7:0], '0, rdata, err);
        check_value(r.name, "pslverr", r.flags[0], err);
        if (!r.flags[0]) begin
          check_value(r.name, "prdata", r.exp, rdata);
        end
      end
      RD_RANGE: begin
        apb_transfer(1'b0, r.addr[7:0], '0, rdata, err);
        check_value(r.name, "pslverr", r.flags[0], err);
        assert (rdata >= r.exp && rdata <= r.data) else begin
          value_errs++;
          $display("ERR %s prdata: expected %0d..%0d, actual %0d", r.name, r.exp,
                   r.data, rdata);
        end
      end
      default: begin
        @(negedge clk);
        user_mode = r.user;
        inst_addr = r.addr;
        data_addr = r.addr;
        inst_en   = (r.kind == XLATE);
        data_en   = (r.kind == XLATE);
        #1;
        check_value(r.name, "inst flags", r.flags[3:1], {inst_unc, inst_miss, inst_ill});
        check_value(r.name, "data flags", r.flags,
                    {data_unc, data_miss, data_ill, data_dirty});
        // address is left open on a miss.
        if (r.kind == XLATE && !r.flags[2]) begin
          check_value(r.name, "inst_addr_o", r.exp, inst_pa);
          check_value(r.name, "data_addr_o", r.exp, data_pa);
        end
      end
    endcase
  endtask

  task automatic build_table();
    mmu_pkg::vpn2_t vpn2;
    mmu_pkg::pfn_t  pfn;
    add_row("kseg0_low", XLATE, 32'h8000_1234, '0, 1'b0, 32'h0000_1234, 4'b0000);
    add_row("kseg0_top", XLATE, 32'h9FFF_FFF0, '0, 1'b0, 32'h1FFF_FFF0, 4'b0000);
    add_row("kseg1_low", XLATE, 32'hA000_0010, '0, 1'b0, 32'h0000_0010, 4'b1000);
    add_row("kseg1_boot", XLATE, 32'hBFC0_0000, '0, 1'b0, 32'h1FC0_0000, 4'b1000);
    add_row("kseg2_empty", XLATE, 32'hC000_0000, '0, 1'b0, '0, 4'b0100);
    add_row("user_kseg0", XLATE, 32'h8000_1234, '0, 1'b1, 32'h0000_1234, 4'b0010);
    add_row("user_kseg1", XLATE, 32'hA000_0000, '0, 1'b1, 32'h0000_0000, 4'b1010);
    add_row("user_kseg2", XLATE, 32'hC000_2000, '0, 1'b1, '0, 4'b0110);
    add_row("user_useg", XLATE, 32'h0040_0000, '0, 1'b1, '0, 4'b0100);
    // disabled ports raise no exception.
    add_row("off_user_kseg2", XLATE_OFF, 32'hC000_2000, '0, 1'b1, '0, 4'b0000);
    add_row("wired_reset", APB_RD, mmu_pkg::REG_WIRED, '0, 1'b0, '0, 4'b0000);
    add_row("index_reset", APB_RD, mmu_pkg::REG_INDEX, '0, 1'b0, '0, 4'b0000);
    // entry 2 has asid 5 and a read-only odd page.
    add_row("hi_e2", APB_WR, mmu_pkg::REG_ENTRYHI, hi_word(19'h200, 8'h05), 1'b0, '0, 4'b0);
    add_row("lo0_e2", APB_WR, mmu_pkg::REG_ENTRYLO0, lo_word(20'h12345, 1'b1, 1'b1, 1'b0),
            1'b0, '0, 4'b0);
    add_row("lo1_e2", APB_WR, mmu_pkg::REG_ENTRYLO1, lo_word(20'h0ABCD, 1'b0, 1'b1, 1'b0),
            1'b0, '0, 4'b0);
    add_row("index_e2", APB_WR, mmu_pkg::REG_INDEX, 32'd2, 1'b0, '0, 4'b0);
    add_row("tlbwi_e2", APB_WR, mmu_pkg::REG_CMD, mmu_pkg::CMD_TLBWI, 1'b0, '0, 4'b0);
    add_row("hi_readback", APB_RD, mmu_pkg::REG_ENTRYHI, '0, 1'b0, hi_word(19'h200, 8'h05),
            4'b0);
    add_row("lo0_readback", APB_RD, mmu_pkg::REG_ENTRYLO0, '0, 1'b0,
            lo_word(20'h12345, 1'b1, 1'b1, 1'b0), 4'b0);
    add_row("useg_even", XLATE, 32'h0040_0123, '0, 1'b1, 32'h1234_5123, 4'b0000);
    add_row("useg_odd_dirty", XLATE, 32'h0040_1FFC, '0, 1'b1, 32'h0ABC_DFFC, 4'b0001);
    add_row("off_odd_dirty", XLATE_OFF, 32'h0040_1FFC, '0, 1'b1, '0, 4'b0000);
    add_row("asid_6", APB_WR, mmu_pkg::REG_ENTRYHI, hi_word(19'h200, 8'h06), 1'b0, '0, 4'b0);
    add_row("useg_asid_miss", XLATE, 32'h0040_0123, '0, 1'b1, '0, 4'b0100);
    // entry 3 is global with the odd half invalid.
    add_row("hi_e3", APB_WR, mmu_pkg::REG_ENTRYHI, hi_word(19'h400, 8'h06), 1'b0, '0, 4'b0);
    add_row("lo0_e3", APB_WR, mmu_pkg::REG_ENTRYLO0, lo_word(20'h00777, 1'b1, 1'b1, 1'b1),
            1'b0, '0, 4'b0);
    add_row("lo1_e3", APB_WR, mmu_pkg::REG_ENTRYLO1, lo_word(20'h00888, 1'b1, 1'b0, 1'b1),
            1'b0, '0, 4'b0);
    add_row("index_e3", APB_WR, mmu_pkg::REG_INDEX, 32'd3, 1'b0, '0, 4'b0);
    add_row("tlbwi_e3", APB_WR, mmu_pkg::REG_CMD, mmu_pkg::CMD_TLBWI, 1'b0, '0, 4'b0);
    add_row("asid_9", APB_WR, mmu_pkg::REG_ENTRYHI, hi_word(19'h400, 8'h09), 1'b0, '0, 4'b0);
    add_row("global_hit", XLATE, 32'h0080_0040, '0, 1'b1, 32'h0077_7040, 4'b0000);
    add_row("v_clear_miss", XLATE, 32'h0080_1000, '0, 1'b1, '0, 4'b0100);
    add_row("hi_probe", APB_WR, mmu_pkg::REG_ENTRYHI, hi_word(19'h200, 8'h05), 1'b0, '0, 4'b0);
    add_row("tlbp_hit", APB_WR, mmu_pkg::REG_CMD, mmu_pkg::CMD_TLBP, 1'b0, '0, 4'b0);
    add_row("index_hit", APB_RD, mmu_pkg::REG_INDEX, '0, 1'b0, 32'd2, 4'b0);
    add_row("hi_unknown", APB_WR, mmu_pkg::REG_ENTRYHI, hi_word(19'h30000, 8'h05), 1'b0, '0,
            4'b0);
    add_row("tlbp_miss", APB_WR, mmu_pkg::REG_CMD, mmu_pkg::CMD_TLBP, 1'b0, '0, 4'b0);
    add_row("index_miss", APB_RD, mmu_pkg::REG_INDEX, '0, 1'b0, 32'h8000_0002, 4'b0);
    add_row("bad_read", APB_RD, 32'h1C, '0, 1'b0, '0, 4'b0001);
    add_row("bad_write", APB_WR, 32'h20, 32'h5, 1'b0, '0, 4'b0001);
    add_row("random_write", APB_WR, mmu_pkg::REG_RANDOM, 32'h7, 1'b0, '0, 4'b0001);
    // random writes land above the four wired entries.
    add_row("wired_4", APB_WR, mmu_pkg::REG_WIRED, 32'd4, 1'b0, '0, 4'b0);
    add_row("wired_readback", APB_RD, mmu_pkg::REG_WIRED, '0, 1'b0, 32'd4, 4'b0);
    for (int i = 0; i < 6; i++) begin
      add_row("random_range", RD_RANGE, mmu_pkg::REG_RANDOM, 32'd15, 1'b0, 32'd4, 4'b0);
    end
    for (int k = 0; k < 2; k++) begin
      // bit 16 set keeps clear of the wired pages.
      vpn2 = {1'b0, k[0], 1'b1, 16'($random(seed))};
      pfn  = 20'($random(seed));
      add_row("hi_rand", APB_WR, mmu_pkg::REG_ENTRYHI, hi_word(vpn2, 8'h05), 1'b0, '0, 4'b0);
      add_row("lo0_rand", APB_WR, mmu_pkg::REG_ENTRYLO0, lo_word(pfn, 1'b1, 1'b1, 1'b0),
              1'b0, '0, 4'b0);
      add_row("lo1_rand", APB_WR, mmu_pkg::REG_ENTRYLO1, lo_word(~pfn, 1'b1, 1'b1, 1'b0),
              1'b0, '0, 4'b0);
      add_row("tlbwr", APB_WR, mmu_pkg::REG_CMD, mmu_pkg::CMD_TLBWR, 1'b0, '0, 4'b0);
      add_row("tlbp_rand", APB_WR, mmu_pkg::REG_CMD, mmu_pkg::CMD_TLBP, 1'b0, '0, 4'b0);
      add_row("index_rand", RD_RANGE, mmu_pkg::REG_INDEX, 32'd15, 1'b0, 32'd4, 4'b0);
      add_row("rand_even", XLATE, {vpn2, 13'h0234}, '0, 1'b1, {pfn, 12'h234}, 4'b0000);
      add_row("rand_odd", XLATE, {vpn2, 13'h10FC}, '0, 1'b1, {~pfn, 12'h0FC}, 4'b0000);
    end
    add_row("wired_e2_kept", XLATE, 32'h0040_0123, '0, 1'b1, 32'h1234_5123, 4'b0000);
    add_row("wired_e3_kept", XLATE, 32'h0080_0040, '0, 1'b1, 32'h0077_7040, 4'b0000);
  endtask

  initial begin
    int prop_fails;
    rst_n      = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    inst_en    = 1'b1;
    data_en    = 1'b1;
    user_mode  = 1'b0;
    inst_addr  = '0;
    data_addr  = '0;
    value_errs = 0;
    timeouts   = 0;
    seed       = 32'h2ef7_108e;
    build_table();
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    foreach (rows[i]) begin
      run_row(rows[i]);
    end
    @(negedge clk);
    prop_fails = i_dut.i_props.fails;
    $display("errors: %0d value, %0d timeout, %0d assertion", value_errs, timeouts,
             prop_fails);
    if (value_errs == 0 && timeouts == 0 && prop_fails == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* test/mmu_props.sv */
`timescale 1ns/1ps

module mmu_props (
  input logic            clk,
  input logic            rst_n_i,
  input logic            psel_i,
  input logic            penable_i,
  input logic            pready_i,
  input logic            user_mode_i,
  input mmu_pkg::vaddr_t inst_addr_i,
  input mmu_pkg::vaddr_t data_addr_i,
  input logic            inst_mapped_i,
  input logic            data_mapped_i,
  input logic            inst_illegal_i,
  input logic            data_illegal_i,
  input logic            inst_miss_i,
  input logic            data_miss_i
);

  int fails = 0;

  // pready only inside an access cycle.
  a_pready_in_access: assert property (@(posedge clk) disable iff (!rst_n_i)
    pready_i |-> psel_i && penable_i)
    else begin
      fails++;
      $error("pready_o went high outside an APB access cycle");
    end

  a_inst_illegal: assert property (@(posedge clk) disable iff (!rst_n_i)
    inst_illegal_i |-> inst_addr_i[31] && user_mode_i)
    else begin
      fails++;
      $error("inst illegal flag without a user-mode kernel address");
    end

  a_data_illegal: assert property (@(posedge clk) disable iff (!rst_n_i)
    data_illegal_i |-> data_addr_i[31] && user_mode_i)
    else begin
      fails++;
      $error("data illegal flag without a user-mode kernel address");
    end

  // unmapped segments never miss.
  a_inst_miss_mapped: assert property (@(posedge clk) disable iff (!rst_n_i)
    inst_miss_i |-> inst_mapped_i)
    else begin
      fails++;
      $error("inst miss raised for an unmapped segment");
    end

  a_data_miss_mapped: assert property (@(posedge clk) disable iff (!rst_n_i)
    data_miss_i |-> data_mapped_i)
    else begin
      fails++;
      $error("data miss raised for an unmapped segment");
    end

endmodule

/* source/mmu_top.sv */
`timescale 1ns/1ps

module mmu_top (
  input  logic               clk,
  input  logic               rst_n_i,
  input  mmu_pkg::vaddr_t    inst_addr_i,
  input  mmu_pkg::vaddr_t    data_addr_i,
  input  logic               inst_en_i,
  input  logic               data_en_i,
  input  logic               user_mode_i,
  input  logic               psel_i,
  input  logic               penable_i,
  input  logic               pwrite_i,
  input  mmu_pkg::apb_addr_t paddr_i,
  input  mmu_pkg::apb_data_t pwdata_i,
  output mmu_pkg::apb_data_t prdata_o,
  output logic               pready_o,
  output logic               pslverr_o,
  output mmu_pkg::paddr_t    inst_addr_o,
  output mmu_pkg::paddr_t    data_addr_o,
  output logic               inst_uncached_o,
  output logic               data_uncached_o,
  output logic               inst_exp_miss_o,
  output logic               data_exp_miss_o,
  output logic               inst_exp_illegal_o,
  output logic               data_exp_illegal_o,
  output logic               data_exp_dirty_o
);

  mmu_pkg::paddr_t   inst_direct, data_direct, inst_tlb_pa, data_tlb_pa;
  logic              inst_mapped, data_mapped;
  logic              inst_tlb_miss, data_tlb_miss, data_tlb_dirty;
  logic              tlb_we, probe_req, probe_hit, wired_we;
  mmu_pkg::tlb_idx_t tlb_widx, probe_idx, wired, random_idx;
  mmu_pkg::vpn2_t    entry_vpn2;
  mmu_pkg::asid_t    entry_asid, cur_asid;
  mmu_pkg::pfn_t     entry_pfn0, entry_pfn1;
  logic              entry_g, entry_d0, entry_v0, entry_d1, entry_v1;

  mem_map i_map_inst (
    .addr_i(inst_addr_i), .en_i(inst_en_i), .user_mode_i(user_mode_i),
    .addr_o(inst_direct), .mapped_o(inst_mapped), .uncached_o(inst_uncached_o),
    .illegal_o(inst_exp_illegal_o)
  );

  mem_map i_map_data (
    .addr_i(data_addr_i), .en_i(data_en_i), .user_mode_i(user_mode_i),
    .addr_o(data_direct), .mapped_o(data_mapped), .uncached_o(data_uncached_o),
    .illegal_o(data_exp_illegal_o)
  );

  tlb i_tlb (
    .clk(clk), .rst_n_i(rst_n_i), .we_i(tlb_we), .widx_i(tlb_widx),
    .wvpn2_i(entry_vpn2), .wasid_i(entry_asid), .wg_i(entry_g),
    .wpfn0_i(entry_pfn0), .wd0_i(entry_d0), .wv0_i(entry_v0),
    .wpfn1_i(entry_pfn1), .wd1_i(entry_d1), .wv1_i(entry_v1),
    .asid_i(cur_asid), .inst_vaddr_i(inst_addr_i), .data_vaddr_i(data_addr_i),
    .inst_paddr_o(inst_tlb_pa), .data_paddr_o(data_tlb_pa),
    .inst_miss_o(inst_tlb_miss), .data_miss_o(data_tlb_miss),
    .data_dirty_o(data_tlb_dirty), .probe_i(probe_req),
    .probe_hit_o(probe_hit), .probe_idx_o(probe_idx)
  );

  tlb_random i_tlb_random (
    .clk(clk), .rst_n_i(rst_n_i), .wired_i(wired), .wired_we_i(wired_we),
    .random_o(random_idx)
  );

  tlb_maint_fsm i_maint (
    .clk(clk), .rst_n_i(rst_n_i), .psel_i(psel_i), .penable_i(penable_i),
    .pwrite_i(pwrite_i), .paddr_i(paddr_i), .pwdata_i(pwdata_i),
    .prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o),
    .random_i(random_idx), .wired_o(wired), .wired_we_o(wired_we),
    .asid_o(cur_asid), .tlb_we_o(tlb_we), .tlb_widx_o(tlb_widx),
    .entry_vpn2_o(entry_vpn2), .entry_asid_o(entry_asid), .entry_g_o(entry_g),
    .entry_pfn0_o(entry_pfn0), .entry_d0_o(entry_d0), .entry_v0_o(entry_v0),
    .entry_pfn1_o(entry_pfn1), .entry_d1_o(entry_d1), .entry_v1_o(entry_v1),
    .probe_o(probe_req), .probe_hit_i(probe_hit), .probe_idx_i(probe_idx)
  );

  // mapped segments take the TLB frame.
  assign inst_addr_o = inst_mapped ? inst_tlb_pa : inst_direct;
  assign data_addr_o = data_mapped ? data_tlb_pa : data_direct;

  assign inst_exp_miss_o  = inst_tlb_miss && inst_mapped && inst_en_i;
  assign data_exp_miss_o  = data_tlb_miss && data_mapped && data_en_i;
  assign data_exp_dirty_o = data_tlb_dirty && data_mapped && data_en_i;

endmodule

/* source/tlb_maint_fsm.sv */
`timescale 1ns/1ps

module tlb_maint_fsm (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               psel_i,
  input  logic               penable_i,
  input  logic               pwrite_i,
  input  mmu_pkg::apb_addr_t paddr_i,
  input  mmu_pkg::apb_data_t pwdata_i,
  output mmu_pkg::apb_data_t prdata_o,
  output logic               pready_o,
  output logic               pslverr_o,
  input  mmu_pkg::tlb_idx_t  random_i,
  output mmu_pkg::tlb_idx_t  wired_o,
  output logic               wired_we_o,
  output mmu_pkg::asid_t     asid_o,
  output logic               tlb_we_o,
  output mmu_pkg::tlb_idx_t  tlb_widx_o,
  output mmu_pkg::vpn2_t     entry_vpn2_o,
  output mmu_pkg::asid_t     entry_asid_o,
  output logic               entry_g_o,
  output mmu_pkg::pfn_t      entry_pfn0_o,
  output logic               entry_d0_o,
  output logic               entry_v0_o,
  output mmu_pkg::pfn_t      entry_pfn1_o,
  output logic               entry_d1_o,
  output logic               entry_v1_o,
  output logic               probe_o,
  input  logic               probe_hit_i,
  input  mmu_pkg::tlb_idx_t  probe_idx_i
);

  mmu_pkg::maint_state_t state_q, state_d;

  mmu_pkg::tlb_idx_t index_q;
  logic              probe_fail_q;
  mmu_pkg::vpn2_t    hi_vpn2_q;
  mmu_pkg::asid_t    hi_asid_q;
  mmu_pkg::pfn_t     lo0_pfn_q, lo1_pfn_q;
  logic [2:0]        lo0_dvg_q, lo1_dvg_q;
  mmu_pkg::tlb_idx_t wired_q;
  logic              probe_hit_q;
  mmu_pkg::tlb_idx_t probe_idx_q;

  logic in_access, cmd_wr, cmd_valid, cmd_go, bad_access, reg_wr;

  assign in_access = (state_q == mmu_pkg::ACCESS);
  assign cmd_wr    = pwrite_i && (paddr_i == mmu_pkg::REG_CMD);
  assign cmd_valid = (pwdata_i == mmu_pkg::CMD_TLBWI) || (pwdata_i == mmu_pkg::CMD_TLBWR) ||
                     (pwdata_i == mmu_pkg::CMD_TLBP);
  assign cmd_go    = cmd_wr && cmd_valid;

  // unknown offsets, RANDOM writes and bad command codes.
  always_comb begin
    case (paddr_i)
      mmu_pkg::REG_INDEX, mmu_pkg::REG_ENTRYHI, mmu_pkg::REG_ENTRYLO0,
      mmu_pkg::REG_ENTRYLO1, mmu_pkg::REG_WIRED: bad_access = 1'b0;
      mmu_pkg::REG_CMD:    bad_access = cmd_wr && !cmd_valid;
      mmu_pkg::REG_RANDOM: bad_access = pwrite_i;
      default:             bad_access = 1'b1;
    endcase
  end

  assign reg_wr = in_access && pwrite_i && !bad_access && !cmd_go;

  always_comb begin
    state_d = state_q;
    case (state_q)
      mmu_pkg::IDLE:   if (psel_i && !penable_i) state_d = mmu_pkg::ACCESS;
      mmu_pkg::ACCESS: state_d = cmd_go ? mmu_pkg::EXEC : mmu_pkg::IDLE;
      default:         state_d = mmu_pkg::IDLE;
    endcase
  end

  // commands hold the bus for one extra cycle.
  assign pready_o   = (in_access && !cmd_go) || (state_q == mmu_pkg::EXEC);
  assign pslverr_o  = in_access && bad_access;
  assign tlb_we_o   = in_access && cmd_go && (pwdata_i != mmu_pkg::CMD_TLBP);
  assign probe_o    = in_access && cmd_go && (pwdata_i == mmu_pkg::CMD_TLBP);
  assign tlb_widx_o = (pwdata_i == mmu_pkg::CMD_TLBWR) ? random_i : index_q;
  assign wired_we_o = reg_wr && (paddr_i == mmu_pkg::REG_WIRED);

  always_comb begin
    case (paddr_i)
      mmu_pkg::REG_INDEX:    prdata_o = {probe_fail_q, 27'd0, index_q};
      mmu_pkg::REG_ENTRYHI:  prdata_o = {hi_vpn2_q, 5'd0, hi_asid_q};
      mmu_pkg::REG_ENTRYLO0: prdata_o = {6'd0, lo0_pfn_q, 3'd0, lo0_dvg_q};
      mmu_pkg::REG_ENTRYLO1: prdata_o = {6'd0, lo1_pfn_q, 3'd0, lo1_dvg_q};
      mmu_pkg::REG_WIRED:    prdata_o = {28'd0, wired_q};
      mmu_pkg::REG_RANDOM:   prdata_o = {28'd0, random_i};
      default:               prdata_o = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q      <= mmu_pkg::IDLE;
      index_q      <= '0;
      probe_fail_q <= 1'b0;
      hi_vpn2_q    <= '0;
      hi_asid_q    <= '0;
      lo0_pfn_q    <= '0;
      lo0_dvg_q    <= '0;
      lo1_pfn_q    <= '0;
      lo1_dvg_q    <= '0;
      wired_q      <= '0;
    end else begin
      state_q <= state_d;
      if (reg_wr) begin
        case (paddr_i)
          mmu_pkg::REG_INDEX: index_q <= pwdata_i[3:0];
          mmu_pkg::REG_ENTRYHI: begin
            hi_vpn2_q <= pwdata_i[31:13];
            hi_asid_q <= pwdata_i[7:0];
          end
          mmu_pkg::REG_ENTRYLO0: begin
            lo0_pfn_q <= pwdata_i[25:6];
            lo0_dvg_q <= pwdata_i[2:0];
          end
          mmu_pkg::REG_ENTRYLO1: begin
            lo1_pfn_q <= pwdata_i[25:6];
            lo1_dvg_q <= pwdata_i[2:0];
          end
          mmu_pkg::REG_WIRED: wired_q <= pwdata_i[3:0];
          default: ;
        endcase
      end
      // a probe miss leaves the old index in place.
      if (state_q == mmu_pkg::EXEC && pwdata_i == mmu_pkg::CMD_TLBP) begin
        probe_fail_q <= !probe_hit_q;
        if (probe_hit_q) begin
          index_q <= probe_idx_q;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (probe_o) begin
      probe_hit_q <= probe_hit_i;
      probe_idx_q <= probe_idx_i;
    end
  end

  assign wired_o      = wired_q;
  assign asid_o       = hi_asid_q;
  assign entry_vpn2_o = hi_vpn2_q;
  assign entry_asid_o = hi_asid_q;
  assign entry_g_o    = lo0_dvg_q[0] && lo1_dvg_q[0];
  assign entry_pfn0_o = lo0_pfn_q;
  assign entry_d0_o   = lo0_dvg_q[2];
  assign entry_v0_o   = lo0_dvg_q[1];
  assign entry_pfn1_o = lo1_pfn_q;
  assign entry_d1_o   = lo1_dvg_q[2];
  assign entry_v1_o   = lo1_dvg_q[1];

endmodule

/* source/tlb_random.sv */
`timescale 1ns/1ps

module tlb_random (
  input  logic              clk,
  input  logic              rst_n_i,
  input  mmu_pkg::tlb_idx_t wired_i,
  input  logic              wired_we_i,
  output mmu_pkg::tlb_idx_t random_o
);

  mmu_pkg::tlb_idx_t random_q;

  // counts down to WIRED, then back to the top entry.
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      random_q <= mmu_pkg::RANDOM_TOP;
    end else if (wired_we_i) begin
      random_q <= mmu_pkg::RANDOM_TOP;
    end else if (random_q == wired_i) begin
      random_q <= mmu_pkg::RANDOM_TOP;
    end else begin
      random_q <= random_q - 4'd1;
    end
  end

  assign random_o = random_q;

endmodule

/* source/tlb.sv */
`timescale 1ns/1ps

module tlb (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              we_i,
  input  mmu_pkg::tlb_idx_t widx_i,
  input  mmu_pkg::vpn2_t    wvpn2_i,
  input  mmu_pkg::asid_t    wasid_i,
  input  logic              wg_i,
  input  mmu_pkg::pfn_t     wpfn0_i,
  input  logic              wd0_i,
  input  logic              wv0_i,
  input  mmu_pkg::pfn_t     wpfn1_i,
  input  logic              wd1_i,
  input  logic              wv1_i,
  input  mmu_pkg::asid_t    asid_i,
  input  mmu_pkg::vaddr_t   inst_vaddr_i,
  input  mmu_pkg::vaddr_t   data_vaddr_i,
  output mmu_pkg::paddr_t   inst_paddr_o,
  output mmu_pkg::paddr_t   data_paddr_o,
  output logic              inst_miss_o,
  output logic              data_miss_o,
  output logic              data_dirty_o,
  input  logic              probe_i,
  output logic              probe_hit_o,
  output mmu_pkg::tlb_idx_t probe_idx_o
);

  mmu_pkg::vpn2_t ent_vpn2 [mmu_pkg::TLB_ENTRIES];
  mmu_pkg::asid_t ent_asid [mmu_pkg::TLB_ENTRIES];
  mmu_pkg::pfn_t  ent_pfn0 [mmu_pkg::TLB_ENTRIES];
  mmu_pkg::pfn_t  ent_pfn1 [mmu_pkg::TLB_ENTRIES];
  logic [mmu_pkg::TLB_ENTRIES-1:0] ent_g;
  logic [mmu_pkg::TLB_ENTRIES-1:0] ent_d0;
  logic [mmu_pkg::TLB_ENTRIES-1:0] ent_d1;
  logic [mmu_pkg::TLB_ENTRIES-1:0] ent_v0;
  logic [mmu_pkg::TLB_ENTRIES-1:0] ent_v1;

  logic [mmu_pkg::TLB_ENTRIES-1:0] inst_match;
  logic [mmu_pkg::TLB_ENTRIES-1:0] data_match;
  logic [mmu_pkg::TLB_ENTRIES-1:0] probe_match;
  mmu_pkg::tlb_idx_t inst_idx;
  mmu_pkg::tlb_idx_t data_idx;
  logic inst_odd;
  logic data_odd;

  // an entry with both halves invalid never matches.
  function automatic logic [mmu_pkg::TLB_ENTRIES-1:0] match_vec(
    input mmu_pkg::vpn2_t vpn2,
    input mmu_pkg::asid_t asid
  );
    logic [mmu_pkg::TLB_ENTRIES-1:0] m;
    for (int i = 0; i < mmu_pkg::TLB_ENTRIES; i++) begin
      m[i] = (ent_v0[i] || ent_v1[i]) && (ent_vpn2[i] == vpn2) &&
             (ent_g[i] || (ent_asid[i] == asid));
    end
    return m;
  endfunction

  // lowest set bit wins.
  function automatic mmu_pkg::tlb_idx_t first_idx(
    input logic [mmu_pkg::TLB_ENTRIES-1:0] m
  );
    mmu_pkg::tlb_idx_t idx;
    idx = '0;
    for (int i = mmu_pkg::TLB_ENTRIES - 1; i >= 0; i--) begin
      if (m[i]) begin
        idx = mmu_pkg::tlb_idx_t'(i);
      end
    end
    return idx;
  endfunction

  assign inst_odd = inst_vaddr_i[mmu_pkg::PAGE_BITS];
  assign data_odd = data_vaddr_i[mmu_pkg::PAGE_BITS];

  always_comb begin
    inst_match   = match_vec(inst_vaddr_i[31:mmu_pkg::PAGE_BITS+1], asid_i);
    inst_idx     = first_idx(inst_match);
    inst_miss_o  = !(|inst_match) ||
                   !(inst_odd ? ent_v1[inst_idx] : ent_v0[inst_idx]);
    inst_paddr_o = '0;
    if (|inst_match) begin
      inst_paddr_o = {inst_odd ? ent_pfn1[inst_idx] : ent_pfn0[inst_idx],
                      inst_vaddr_i[mmu_pkg::PAGE_BITS-1:0]};
    end
  end

  always_comb begin
    data_match   = match_vec(data_vaddr_i[31:mmu_pkg::PAGE_BITS+1], asid_i);
    data_idx     = first_idx(data_match);
    data_miss_o  = !(|data_match) ||
                   !(data_odd ? ent_v1[data_idx] : ent_v0[data_idx]);
    data_dirty_o = !data_miss_o &&
                   !(data_odd ? ent_d1[data_idx] : ent_d0[data_idx]);
    data_paddr_o = '0;
    if (|data_match) begin
      data_paddr_o = {data_odd ? ent_pfn1[data_idx] : ent_pfn0[data_idx],
                      data_vaddr_i[mmu_pkg::PAGE_BITS-1:0]};
    end
  end

  // probe against the ENTRYHI pair.
  assign probe_match = match_vec(wvpn2_i, wasid_i);
  assign probe_hit_o = probe_i && (|probe_match);
  assign probe_idx_o = first_idx(probe_match);

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ent_v0 <= '0;
      ent_v1 <= '0;
    end else if (we_i) begin
      ent_v0[widx_i] <= wv0_i;
      ent_v1[widx_i] <= wv1_i;
    end
  end

  always_ff @(posedge clk) begin
    if (we_i) begin
      ent_vpn2[widx_i] <= wvpn2_i;
      ent_asid[widx_i] <= wasid_i;
      ent_g[widx_i]    <= wg_i;
      ent_pfn0[widx_i] <= wpfn0_i;
      ent_d0[widx_i]   <= wd0_i;
      ent_pfn1[widx_i] <= wpfn1_i;
      ent_d1[widx_i]   <= wd1_i;
    end
  end

endmodule

/* source/mem_map.sv */
`timescale 1ns/1ps

module mem_map (
  input  mmu_pkg::vaddr_t addr_i,
  input  logic            en_i,
  input  logic            user_mode_i,
  output mmu_pkg::paddr_t addr_o,
  output logic            mapped_o,
  output logic            uncached_o,
  output logic            illegal_o
);

  logic [2:0] seg;

  assign seg = addr_i[31:29];

  always_comb begin
    addr_o     = addr_i;
    mapped_o   = 1'b1;
    uncached_o = 1'b0;
    case (seg)
      // kseg0, unmapped and cached.
      3'b100: begin
        addr_o   = addr_i - mmu_pkg::KSEG0_BASE;
        mapped_o = 1'b0;
      end
      // kseg1, unmapped and uncached.
      3'b101: begin
        addr_o     = addr_i - mmu_pkg::KSEG1_BASE;
        mapped_o   = 1'b0;
        uncached_o = 1'b1;
      end
      // useg, kseg2 and kseg3 go through the TLB.
      default: begin
        addr_o     = addr_i;
        mapped_o   = 1'b1;
        uncached_o = 1'b0;
      end
    endcase
  end

  // kernel segments start at bit 31.
  assign illegal_o = en_i && user_mode_i && addr_i[31];

endmodule

/* source/mmu_pkg.sv */
package mmu_pkg;

  // address and field widths.
  typedef logic [31:0] vaddr_t;
  typedef logic [31:0] paddr_t;
  typedef logic [18:0] vpn2_t;
  typedef logic [19:0] pfn_t;
  typedef logic [7:0]  asid_t;
  typedef logic [3:0]  tlb_idx_t;

  typedef logic [7:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  localparam int TLB_ENTRIES = 16;

  // 4 KiB pages, bit 12 picks the even or odd half of a pair.
  localparam int PAGE_BITS = 12;

  localparam tlb_idx_t RANDOM_TOP = tlb_idx_t'(TLB_ENTRIES - 1);

  // maintenance register offsets.
  localparam apb_addr_t REG_INDEX    = 8'h00;
  localparam apb_addr_t REG_ENTRYHI  = 8'h04;
  localparam apb_addr_t REG_ENTRYLO0 = 8'h08;
  localparam apb_addr_t REG_ENTRYLO1 = 8'h0C;
  localparam apb_addr_t REG_WIRED    = 8'h10;
  localparam apb_addr_t REG_RANDOM   = 8'h14;
  localparam apb_addr_t REG_CMD      = 8'h18;

  // command codes written to CMD.
  localparam apb_data_t CMD_TLBWI = 32'd1;
  localparam apb_data_t CMD_TLBWR = 32'd2;
  localparam apb_data_t CMD_TLBP  = 32'd3;

  // unmapped segment bases.
  localparam vaddr_t KSEG0_BASE = 32'h8000_0000;
  localparam vaddr_t KSEG1_BASE = 32'hA000_0000;

  // APB maintenance controller states.
  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    EXEC
  } maint_state_t;

endpackage
